//--- hdl/csr_defs.svh
// Architectural widths, machine CSR addresses and fixed values of the CSR subsystem.

`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data width of the core.
`define XLEN 64

// CSR address width from the instruction encoding.
`define CSR_AW 12

// machine-mode CSR addresses.
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// mstatus comes out of reset with SXL, UXL and MPP set for a 64-bit machine-mode core.
`define MSTATUS_RST 64'ha00001800

// exception code of an environment call from machine mode.
`define CAUSE_ECALL_M 11

// interrupt enable bits inside mstatus.
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

`endif

//--- hdl/csr_pkg.sv
// CSR subsystem package with the instruction opcode, trap kind and trap FSM state types.

package csr_pkg;

  // opcode encoding follows the low two bits of funct3 for the register forms.
  typedef enum logic [1:0] {
    CSRRW = 2'b01, // write the source, return the old value.
    CSRRS = 2'b10, // set the source bits.
    CSRRC = 2'b11  // clear the source bits.
  } csr_op_e;

  // kind of trap sequence that is in flight.
  typedef enum logic {
    TRAP_ECALL = 1'b0,
    TRAP_MRET  = 1'b1
  } trap_kind_e;

  // each state after IDLE is one access on the CSR port.
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    ST_RMW    = 3'd1, // read-modify-write of mstatus.
    WR_EPC    = 3'd2,
    WR_CAUSE  = 3'd3,
    RD_TARGET = 3'd4, // read of mtvec or mepc.
    DONE      = 3'd5
  } trap_state_e;

endpackage

//--- hdl/csr_file.sv
// Machine CSR register file with mstatus, mtvec, mepc and mcause behind one access port.

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_file (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_en,
  input  logic [`CSR_AW-1:0] i_addr,
  input  logic               i_we,
  input  logic [`XLEN-1:0]   i_wdata,
  output logic [`XLEN-1:0]   o_rdata,
  output logic               o_hit
);

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;
  logic             wr_en;

  // address decode. anything outside the four registers reads as zero.
  always_comb begin
    o_hit   = 1'b1;
    o_rdata = '0;
    case (i_addr)
      `CSR_MSTATUS: o_rdata = mstatus;
      `CSR_MTVEC:   o_rdata = mtvec;
      `CSR_MEPC:    o_rdata = mepc;
      `CSR_MCAUSE:  o_rdata = mcause;
      default:      o_hit   = 1'b0;
    endcase
  end

  assign wr_en = i_en && i_we && o_hit; // only a legal address may be written.

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mstatus <= `MSTATUS_RST;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (wr_en) begin
      case (i_addr)
        `CSR_MSTATUS: mstatus <= i_wdata;
        `CSR_MTVEC:   mtvec   <= i_wdata;
        `CSR_MEPC:    mepc    <= i_wdata;
        `CSR_MCAUSE:  mcause  <= i_wdata;
        default:      ;
      endcase
    end
  end

  // the arbiter must never present a write on an idle port.
  a_we_needs_en: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_we |-> i_en
  ) else $error("csr_file: write enable without port enable");

endmodule

//--- hdl/csr_bus_arbiter.sv
// Fixed-priority arbiter giving the trap sequencer or the exec unit the CSR file port.

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_bus_arbiter (
  input  logic               i_clk,
  input  logic               i_rst_n,
  // trap sequencer side has the higher priority.
  input  logic               i_trap_req,
  input  logic [`CSR_AW-1:0] i_trap_addr,
  input  logic               i_trap_we,
  input  logic [`XLEN-1:0]   i_trap_wdata,
  output logic               o_trap_gnt,
  // CSR instruction side.
  input  logic               i_exec_req,
  input  logic [`CSR_AW-1:0] i_exec_addr,
  input  logic               i_exec_we,
  input  logic [`XLEN-1:0]   i_exec_wdata,
  output logic               o_exec_gnt,
  // register file port.
  output logic               o_en,
  output logic [`CSR_AW-1:0] o_addr,
  output logic               o_we,
  output logic [`XLEN-1:0]   o_wdata
);

  assign o_trap_gnt = i_trap_req;
  assign o_exec_gnt = i_exec_req && !i_trap_req; // waits while a trap sequence runs.

  assign o_en = o_trap_gnt || o_exec_gnt;

  always_comb begin
    if (o_trap_gnt) begin
      o_addr  = i_trap_addr;
      o_we    = i_trap_we;
      o_wdata = i_trap_wdata;
    end else begin
      o_addr  = i_exec_addr;
      o_we    = o_exec_gnt && i_exec_we; // no write leaks out of an idle cycle.
      o_wdata = i_exec_wdata;
    end
  end

  // a waiting exec request stays up until the port is granted to it.
  a_exec_req_held: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_exec_req && !o_exec_gnt |=> i_exec_req
  ) else $error("csr_bus_arbiter: exec request dropped before its grant");

  // a full ecall holds the port for four cycles, so eight leaves room for a back-to-back trap.
  a_exec_no_starve: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_exec_req |-> ##[0:7] o_exec_gnt
  ) else $error("csr_bus_arbiter: exec request starved");

endmodule

//--- hdl/csr_exec_unit.sv
// CSR instruction unit running csrrw, csrrs and csrrc as one read-modify-write access.

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_exec_unit (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_csr_valid,
  input  csr_pkg::csr_op_e   i_csr_op,
  input  logic [`CSR_AW-1:0] i_csr_addr,
  input  logic [`XLEN-1:0]   i_csr_src,
  output logic               o_req,
  output logic [`CSR_AW-1:0] o_addr,
  output logic               o_we,
  output logic [`XLEN-1:0]   o_wdata,
  input  logic               i_gnt,
  input  logic [`XLEN-1:0]   i_rdata,
  input  logic               i_hit,
  output logic               o_csr_done,
  output logic [`XLEN-1:0]   o_csr_rdata,
  output logic               o_csr_illegal
);

  import csr_pkg::*;

  logic               req_q;
  logic               done_q;
  logic               illegal_q;
  csr_op_e            op_q;
  logic [`CSR_AW-1:0] addr_q;
  logic [`XLEN-1:0]   src_q;
  logic [`XLEN-1:0]   rdata_q;
  logic               skip_wr;

  // set and clear with a zero source are pure reads.
  assign skip_wr = (op_q != CSRRW) && (src_q == '0);

  always_comb begin
    case (op_q)
      CSRRW:   o_wdata = src_q;
      CSRRS:   o_wdata = i_rdata | src_q;
      CSRRC:   o_wdata = i_rdata & ~src_q;
      default: o_wdata = i_rdata;
    endcase
  end

  assign o_req  = req_q;
  assign o_addr = addr_q;
  assign o_we   = req_q && i_hit && !skip_wr;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      req_q     <= 1'b0;
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_csr_valid) begin
        req_q <= 1'b1;
      end else if (req_q && i_gnt) begin
        req_q     <= 1'b0;
        done_q    <= 1'b1;
        illegal_q <= !i_hit;
      end
    end
  end

  // instruction fields and the returned old value.
  always_ff @(posedge i_clk) begin
    if (i_csr_valid) begin
      op_q   <= i_csr_op;
      addr_q <= i_csr_addr;
      src_q  <= i_csr_src;
    end
    if (req_q && i_gnt) rdata_q <= i_rdata; // the file already returns zero on a miss.
  end

  assign o_csr_done    = done_q;
  assign o_csr_rdata   = rdata_q;
  assign o_csr_illegal = illegal_q;

endmodule

//--- hdl/trap_sequencer.sv
// Trap sequencer that walks ecall and mret through the CSR port and produces the redirect PC.

`timescale 1ns/100ps

`include "csr_defs.svh"

module trap_sequencer (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_ecall,
  input  logic [`XLEN-1:0]   i_epc,
  input  logic               i_mret,
  output logic               o_req,
  output logic [`CSR_AW-1:0] o_addr,
  output logic               o_we,
  output logic [`XLEN-1:0]   o_wdata,
  input  logic               i_gnt,
  input  logic [`XLEN-1:0]   i_rdata,
  output logic               o_redirect_valid,
  output logic [`XLEN-1:0]   o_redirect_pc
);

  import csr_pkg::*;

  trap_state_e      state_q;
  trap_state_e      state_d;
  trap_kind_e       kind_q;
  logic [`XLEN-1:0] epc_q;
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] mstatus_new;

  // new mstatus built from the value read in the same granted cycle.
  always_comb begin
    mstatus_new = i_rdata;
    if (kind_q == TRAP_ECALL) begin
      mstatus_new[`MSTATUS_MPIE] = i_rdata[`MSTATUS_MIE];
      mstatus_new[`MSTATUS_MIE]  = 1'b0;
    end else begin
      mstatus_new[`MSTATUS_MIE]  = i_rdata[`MSTATUS_MPIE];
      mstatus_new[`MSTATUS_MPIE] = 1'b1;
    end
  end

  // one CSR access per state. the request stays up across the whole sequence.
  always_comb begin
    o_req   = 1'b1;
    o_addr  = `CSR_MSTATUS;
    o_we    = 1'b0;
    o_wdata = mstatus_new;
    case (state_q)
      ST_RMW: begin
        o_we = 1'b1;
      end
      WR_EPC: begin
        o_addr  = `CSR_MEPC;
        o_we    = 1'b1;
        o_wdata = epc_q;
      end
      WR_CAUSE: begin
        o_addr  = `CSR_MCAUSE;
        o_we    = 1'b1;
        o_wdata = `XLEN'(`CAUSE_ECALL_M);
      end
      RD_TARGET: o_addr = (kind_q == TRAP_ECALL) ? `CSR_MTVEC : `CSR_MEPC;
      default:   o_req  = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (i_ecall || i_mret) state_d = ST_RMW;
      ST_RMW: begin
        if (i_gnt) state_d = (kind_q == TRAP_ECALL) ? WR_EPC : RD_TARGET;
      end
      WR_EPC:    if (i_gnt) state_d = WR_CAUSE;
      WR_CAUSE:  if (i_gnt) state_d = RD_TARGET;
      RD_TARGET: if (i_gnt) state_d = DONE;
      default:   state_d = IDLE; // DONE lasts one cycle.
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == IDLE && (i_ecall || i_mret)) begin
      kind_q <= i_ecall ? TRAP_ECALL : TRAP_MRET;
      epc_q  <= i_epc;
    end
    if (state_q == RD_TARGET && i_gnt) pc_q <= i_rdata;
  end

  assign o_redirect_valid = (state_q == DONE);
  assign o_redirect_pc    = pc_q;

  a_one_trap_kind: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(i_ecall && i_mret)
  ) else $error("trap_sequencer: ecall and mret in the same cycle");

endmodule

//--- hdl/csr_subsystem_top.sv
// Top level of the machine CSR subsystem joining both peers, the arbiter and the register file.

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_subsystem_top (
  input  logic               i_clk,
  input  logic               i_rst_n,
  // CSR instructions.
  input  logic               i_csr_valid,
  input  csr_pkg::csr_op_e   i_csr_op,
  input  logic [`CSR_AW-1:0] i_csr_addr,
  input  logic [`XLEN-1:0]   i_csr_src,
  output logic               o_csr_done,
  output logic [`XLEN-1:0]   o_csr_rdata,
  output logic               o_csr_illegal,
  // traps.
  input  logic               i_ecall,
  input  logic [`XLEN-1:0]   i_epc,
  input  logic               i_mret,
  output logic               o_redirect_valid,
  output logic [`XLEN-1:0]   o_redirect_pc
);

  logic               exec_req;
  logic [`CSR_AW-1:0] exec_addr;
  logic               exec_we;
  logic [`XLEN-1:0]   exec_wdata;
  logic               exec_gnt;
  logic               trap_req;
  logic [`CSR_AW-1:0] trap_addr;
  logic               trap_we;
  logic [`XLEN-1:0]   trap_wdata;
  logic               trap_gnt;
  logic               csr_en;
  logic [`CSR_AW-1:0] csr_addr;
  logic               csr_we;
  logic [`XLEN-1:0]   csr_wdata;
  logic [`XLEN-1:0]   csr_rdata; // shared by both peers.
  logic               csr_hit;

  csr_exec_unit u_exec (
    .i_clk, .i_rst_n,
    .i_csr_valid, .i_csr_op, .i_csr_addr, .i_csr_src,
    .o_req(exec_req), .o_addr(exec_addr), .o_we(exec_we), .o_wdata(exec_wdata),
    .i_gnt(exec_gnt), .i_rdata(csr_rdata), .i_hit(csr_hit),
    .o_csr_done, .o_csr_rdata, .o_csr_illegal
  );

  trap_sequencer u_trap (
    .i_clk, .i_rst_n, .i_ecall, .i_epc, .i_mret,
    .o_req(trap_req), .o_addr(trap_addr), .o_we(trap_we), .o_wdata(trap_wdata),
    .i_gnt(trap_gnt), .i_rdata(csr_rdata),
    .o_redirect_valid, .o_redirect_pc
  );

  csr_bus_arbiter u_arb (
    .i_clk, .i_rst_n,
    .i_trap_req(trap_req), .i_trap_addr(trap_addr), .i_trap_we(trap_we),
    .i_trap_wdata(trap_wdata), .o_trap_gnt(trap_gnt),
    .i_exec_req(exec_req), .i_exec_addr(exec_addr), .i_exec_we(exec_we),
    .i_exec_wdata(exec_wdata), .o_exec_gnt(exec_gnt),
    .o_en(csr_en), .o_addr(csr_addr), .o_we(csr_we), .o_wdata(csr_wdata)
  );

  csr_file u_csr (
    .i_clk, .i_rst_n,
    .i_en(csr_en), .i_addr(csr_addr), .i_we(csr_we), .i_wdata(csr_wdata),
    .o_rdata(csr_rdata), .o_hit(csr_hit)
  );

endmodule

//--- verification/csr_checker.sv
// Scoreboard for the CSR subsystem that models the four machine CSRs and compares DUT results.

`timescale 1ns/100ps

`include "csr_defs.svh"

module csr_checker (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_csr_valid,
  input  csr_pkg::csr_op_e   i_csr_op,
  input  logic [`CSR_AW-1:0] i_csr_addr,
  input  logic [`XLEN-1:0]   i_csr_src,
  input  logic               i_csr_done,
  input  logic [`XLEN-1:0]   i_csr_rdata,
  input  logic               i_csr_illegal,
  input  logic               i_ecall,
  input  logic [`XLEN-1:0]   i_epc,
  input  logic               i_mret,
  input  logic               i_redirect_valid,
  input  logic [`XLEN-1:0]   i_redirect_pc,
  output int                 o_checks,
  output int                 o_errors
);

  import csr_pkg::*;

  localparam int MAX_WAIT = 12; // longest legal wait for o_csr_done with some margin.

  logic [`XLEN-1:0] model [4]; // mstatus, mtvec, mepc, mcause in that order.
  logic [`XLEN-1:0] exp_rdata_q [$];
  logic             exp_ill_q [$];
  logic             exp_late_q [$]; // the instruction shared its strobe cycle with a trap.
  int               instr_start_q [$];
  logic [`XLEN-1:0] exp_pc_q [$];
  int               trap_due_q [$];
  logic [`XLEN-1:0] exp_old;
  logic             exp_ill;
  int               cyc;
  int               checks = 0;
  int               errors = 0;

  assign o_checks = checks;
  assign o_errors = errors;

  function automatic int csr_index(input logic [`CSR_AW-1:0] addr);
    case (addr)
      `CSR_MSTATUS: return 0;
      `CSR_MTVEC:   return 1;
      `CSR_MEPC:    return 2;
      `CSR_MCAUSE:  return 3;
      default:      return -1;
    endcase
  endfunction

  // expected old value and illegal flag of one instruction. the model moves to its new state.
  function automatic void ref_instr(input csr_op_e op, input logic [`CSR_AW-1:0] addr,
                                    input logic [`XLEN-1:0] src,
                                    output logic [`XLEN-1:0] old_val, output logic illegal);
    int idx;
    idx     = csr_index(addr);
    illegal = (idx < 0);
    old_val = '0;
    if (!illegal) begin
      old_val = model[idx];
      case (op)
        CSRRW:   model[idx] = src;
        CSRRS:   if (src != '0) model[idx] = old_val | src;
        CSRRC:   if (src != '0) model[idx] = old_val & ~src;
        default: ;
      endcase
    end
  endfunction

  // expected redirect PC of an ecall or an mret, with the CSR updates of the trap.
  function automatic logic [`XLEN-1:0] ref_trap(input logic is_ecall,
                                                input logic [`XLEN-1:0] epc);
    logic [`XLEN-1:0] st;
    logic [`XLEN-1:0] target;
    st = model[0];
    if (is_ecall) begin
      target             = model[1];
      st[`MSTATUS_MPIE]  = model[0][`MSTATUS_MIE];
      st[`MSTATUS_MIE]   = 1'b0;
      model[2]           = epc;
      model[3]           = `XLEN'(`CAUSE_ECALL_M);
    end else begin
      target             = model[2];
      st[`MSTATUS_MIE]   = model[0][`MSTATUS_MPIE];
      st[`MSTATUS_MPIE]  = 1'b1;
    end
    model[0] = st;
    return target;
  endfunction

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      model[0] = `MSTATUS_RST;
      model[1] = '0;
      model[2] = '0;
      model[3] = '0;
      cyc      = 0;
      exp_rdata_q.delete();
      exp_ill_q.delete();
      exp_late_q.delete();
      instr_start_q.delete();
      exp_pc_q.delete();
      trap_due_q.delete();
    end else begin
      cyc = cyc + 1;
      // a trap strobed together with an instruction owns the port first.
      if (i_ecall || i_mret) begin
        exp_pc_q.push_back(ref_trap(i_ecall, i_epc));
        trap_due_q.push_back(cyc + (i_ecall ? 5 : 3));
      end
      if (i_csr_valid) begin
        ref_instr(i_csr_op, i_csr_addr, i_csr_src, exp_old, exp_ill);
        exp_rdata_q.push_back(exp_old);
        exp_ill_q.push_back(exp_ill);
        exp_late_q.push_back(i_ecall || i_mret);
        instr_start_q.push_back(cyc);
      end
      if (i_redirect_valid) begin
        if (exp_pc_q.size() == 0) begin
          $display("%0t: a redirect arrived while no trap was outstanding", $time);
          errors++;
        end else begin
          checks++;
          if (cyc != trap_due_q[0]) begin
            $display("FAIL %0t: redirect came %0d cycles off its fixed latency",
                     $time, cyc - trap_due_q[0]);
            errors++;
          end
          if (i_redirect_pc !== exp_pc_q[0]) begin
            $display("FAIL %0t: redirect pc %h, expected %h", $time, i_redirect_pc, exp_pc_q[0]);
            errors++;
          end
          void'(exp_pc_q.pop_front());
          void'(trap_due_q.pop_front());
        end
      end else if (exp_pc_q.size() > 0 && cyc > trap_due_q[0]) begin
        $display("%0t: the trap redirect did not arrive in the cycle it was due", $time);
        errors++;
        void'(exp_pc_q.pop_front());
        void'(trap_due_q.pop_front());
      end
      if (i_csr_done) begin
        if (exp_rdata_q.size() == 0) begin
          $display("%0t: o_csr_done arrived while no instruction was outstanding", $time);
          errors++;
        end else begin
          checks++;
          if (exp_late_q[0] && exp_pc_q.size() > 0) begin
            $display("FAIL %0t: instruction finished before the trap redirect", $time);
            errors++;
          end
          if (i_csr_rdata !== exp_rdata_q[0] || i_csr_illegal !== exp_ill_q[0]) begin
            $display("FAIL %0t: csr result %h illegal %b, expected %h illegal %b", $time,
                     i_csr_rdata, i_csr_illegal, exp_rdata_q[0], exp_ill_q[0]);
            errors++;
          end
          void'(exp_rdata_q.pop_front());
          void'(exp_ill_q.pop_front());
          void'(exp_late_q.pop_front());
          void'(instr_start_q.pop_front());
        end
      end else if (instr_start_q.size() > 0 && cyc - instr_start_q[0] > MAX_WAIT) begin
        $display("%0t: no o_csr_done arrived within %0d cycles of the instruction",
                 $time, MAX_WAIT);
        errors++;
        void'(exp_rdata_q.pop_front());
        void'(exp_ill_q.pop_front());
        void'(exp_late_q.pop_front());
        void'(instr_start_q.pop_front());
      end
    end
  end

endmodule

//--- verification/tb_csr_top.sv
// Testbench top for the CSR subsystem with clock, reset, LCG stimulus, test sequence and timeout.

`timescale 1ns/100ps

`include "csr_defs.svh"

module tb_csr_top;

  import csr_pkg::*;

  localparam int CYCLE_LIMIT = 6000; // about 300 operations at up to 8 cycles, plus reset.
  localparam int WAIT_LIMIT  = 24;

  logic               clk;
  logic               rst_n;
  logic               csr_valid;
  csr_op_e            csr_op;
  logic [`CSR_AW-1:0] csr_addr;
  logic [`XLEN-1:0]   csr_src;
  logic               csr_done;
  logic [`XLEN-1:0]   csr_rdata;
  logic               csr_illegal;
  logic               ecall;
  logic [`XLEN-1:0]   epc;
  logic               mret;
  logic               redirect_valid;
  logic [`XLEN-1:0]   redirect_pc;
  int                 checks;
  int                 errors;
  int                 errors_before;
  int                 cycle_cnt;
  logic [31:0]        lcg_state;
  logic [31:0]        r;
  logic [`XLEN-1:0]   src;
  csr_op_e            op;
  logic [`CSR_AW-1:0] legal_addr [4];
  logic [`CSR_AW-1:0] near_addr [3];

  csr_subsystem_top u_dut (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_csr_valid(csr_valid), .i_csr_op(csr_op), .i_csr_addr(csr_addr), .i_csr_src(csr_src),
    .o_csr_done(csr_done), .o_csr_rdata(csr_rdata), .o_csr_illegal(csr_illegal),
    .i_ecall(ecall), .i_epc(epc), .i_mret(mret),
    .o_redirect_valid(redirect_valid), .o_redirect_pc(redirect_pc)
  );

  csr_checker u_chk (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_csr_valid(csr_valid), .i_csr_op(csr_op), .i_csr_addr(csr_addr), .i_csr_src(csr_src),
    .i_csr_done(csr_done), .i_csr_rdata(csr_rdata), .i_csr_illegal(csr_illegal),
    .i_ecall(ecall), .i_epc(epc), .i_mret(mret),
    .i_redirect_valid(redirect_valid), .i_redirect_pc(redirect_pc),
    .o_checks(checks), .o_errors(errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // drives the strobes for one cycle, then waits until every expected response was seen.
  task automatic issue(input logic do_instr, input logic do_trap, input logic is_ecall,
                       input csr_op_e i_op, input logic [`CSR_AW-1:0] i_addr,
                       input logic [`XLEN-1:0] i_src, input logic [`XLEN-1:0] i_pc);
    int   waited;
    logic got_done;
    logic got_redirect;
    csr_valid = do_instr;
    csr_op    = i_op;
    csr_addr  = i_addr;
    csr_src   = i_src;
    ecall     = do_trap && is_ecall;
    mret      = do_trap && !is_ecall;
    epc       = i_pc;
    @(posedge clk);
    #1;
    csr_valid    = 1'b0;
    ecall        = 1'b0;
    mret         = 1'b0;
    waited       = 0;
    got_done     = !do_instr;
    got_redirect = !do_trap;
    do begin
      @(posedge clk);
      waited++;
      if (csr_done) got_done = 1'b1;
      if (redirect_valid) got_redirect = 1'b1;
    end while (!(got_done && got_redirect) && waited < WAIT_LIMIT);
    #1;
  endtask

  task automatic run_instr(input csr_op_e i_op, input logic [`CSR_AW-1:0] i_addr,
                           input logic [`XLEN-1:0] i_src);
    issue(1'b1, 1'b0, 1'b0, i_op, i_addr, i_src, '0);
  endtask

  task automatic read_all();
    for (int i = 0; i < 4; i++) run_instr(CSRRS, legal_addr[i], '0); // zero source only reads.
  endtask

  task automatic report_test(input string name);
    $display("test %-12s done, %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  initial begin
    lcg_state     = 32'h0f398076;
    legal_addr[0] = `CSR_MSTATUS;
    legal_addr[1] = `CSR_MTVEC;
    legal_addr[2] = `CSR_MEPC;
    legal_addr[3] = `CSR_MCAUSE;
    near_addr[0]  = 12'h301;
    near_addr[1]  = 12'h340;
    near_addr[2]  = 12'h343;
    rst_n         = 1'b0;
    csr_valid     = 1'b0;
    csr_op        = CSRRW;
    csr_addr      = '0;
    csr_src       = '0;
    ecall         = 1'b0;
    epc           = '0;
    mret          = 1'b0;
    errors_before = 0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    read_all();
    report_test("reset");

    repeat (200) begin
      r   = lcg_next();
      src = {lcg_next(), lcg_next()};
      case (r[29:28])
        2'd0:    op = CSRRS;
        2'd1:    op = CSRRC;
        default: op = CSRRW;
      endcase
      if (r[27:25] == 3'd0) src = '0; // zero source exercises the no-write rule.
      run_instr(op, legal_addr[r[31:30]], src);
    end
    read_all();
    report_test("random");

    for (int i = 0; i < 8; i++) begin
      r = lcg_next();
      run_instr(CSRRW, (i < 3) ? near_addr[i] : {4'hb, r[27:20]}, {lcg_next(), lcg_next()});
    end
    read_all();
    report_test("illegal");

    run_instr(CSRRW, `CSR_MTVEC, {lcg_next(), lcg_next() & 32'hffff_fffc});
    run_instr(CSRRS, `CSR_MSTATUS, 64'h8); // MIE set so that the ecall moves it to MPIE.
    issue(1'b0, 1'b1, 1'b1, CSRRW, '0, '0, {lcg_next(), lcg_next() & 32'hffff_fffc});
    read_all();
    report_test("ecall");

    run_instr(CSRRC, `CSR_MSTATUS, 64'h80);
    issue(1'b0, 1'b1, 1'b0, CSRRW, '0, '0, '0);
    read_all();
    issue(1'b0, 1'b1, 1'b0, CSRRW, '0, '0, '0); // MPIE is now 1, so MIE comes back set.
    read_all();
    report_test("mret");

    run_instr(CSRRW, `CSR_MTVEC, {lcg_next(), lcg_next() & 32'hffff_fffc});
    issue(1'b1, 1'b1, 1'b1, CSRRS, `CSR_MEPC, '0, {lcg_next(), lcg_next()});
    issue(1'b1, 1'b1, 1'b1, CSRRW, `CSR_MCAUSE, 64'h5, {lcg_next(), lcg_next()});
    read_all();
    report_test("contention");

    repeat (2) @(posedge clk);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- all.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_file.sv
hdl/csr_bus_arbiter.sv
hdl/csr_exec_unit.sv
hdl/trap_sequencer.sv
hdl/csr_subsystem_top.sv
verification/csr_checker.sv
verification/tb_csr_top.sv

//--- Bender.yml
package:
  name: csr_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/csr_file.sv
      - hdl/csr_bus_arbiter.sv
      - hdl/csr_exec_unit.sv
      - hdl/trap_sequencer.sv
      - hdl/csr_subsystem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/csr_checker.sv
      - verification/tb_csr_top.sv
